// File: design/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// operand and address width, sign extension assumes 32
`define LSU_WIDTH 32

// or1k load opcodes, bits 5:4 == 2
`define LSU_OP_LWZ 6'h21
`define LSU_OP_LWS 6'h22
`define LSU_OP_LBZ 6'h23
`define LSU_OP_LBS 6'h24
`define LSU_OP_LHZ 6'h25
`define LSU_OP_LHS 6'h26

// or1k store opcodes, bits 5:4 == 3
`define LSU_OP_SW 6'h35
`define LSU_OP_SB 6'h36
`define LSU_OP_SH 6'h37

`define LSU_RAM_WORDS 256 // 1 KiB data ram

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_DECERR 2'b11

`endif

// File: design/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

   // one memory command from the pipeline side
   typedef struct packed {
      logic [5:0]            opcode;
      logic [`LSU_WIDTH-1:0] addr;
      logic [`LSU_WIDTH-1:0] wdata; // store operand, unreplicated
   } lsu_cmd_t;

   typedef struct packed {
      logic                  valid;        // single cycle pulse
      logic [`LSU_WIDTH-1:0] result;       // aligned, extended load data
      logic                  except_align;
      logic                  except_bus;
   } lsu_rsp_t;

   // simple req/ack data bus
   typedef struct packed {
      logic                  req;
      logic                  we;
      logic [`LSU_WIDTH-1:0] adr;
      logic [`LSU_WIDTH-1:0] dat;
      logic [3:0]            bsel; // bit 3 = bits 31:24
   } dbus_req_t;

   typedef struct packed {
      logic                  ack;
      logic                  err;
      logic [`LSU_WIDTH-1:0] dat; // valid with ack on loads
   } dbus_rsp_t;

   // axi4-lite, master to slave
   typedef struct packed {
      logic                  awvalid;
      logic [`LSU_WIDTH-1:0] awaddr;
      logic                  wvalid;
      logic [`LSU_WIDTH-1:0] wdata;
      logic [3:0]            wstrb;
      logic                  bready;
      logic                  arvalid;
      logic [`LSU_WIDTH-1:0] araddr;
      logic                  rready;
   } axil_req_t;

   // axi4-lite, slave to master
   typedef struct packed {
      logic                  awready;
      logic                  wready;
      logic                  bvalid;
      logic [1:0]            bresp;
      logic                  arready;
      logic                  rvalid;
      logic [`LSU_WIDTH-1:0] rdata;
      logic [1:0]            rresp;
   } axil_rsp_t;

endpackage

`default_nettype wire

// File: design/lsu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_unit
(
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 cmd_valid_i,
   input  lsu_pkg::lsu_cmd_t   cmd_i,
   output logic                cmd_ready_o,
   output lsu_pkg::lsu_rsp_t   rsp_o,
   output lsu_pkg::dbus_req_t  dbus_req_o,
   input  lsu_pkg::dbus_rsp_t  dbus_rsp_i
);

   localparam logic [1:0] S_IDLE   = 2'd0;
   localparam logic [1:0] S_ACCESS = 2'd1; // bus request outstanding
   localparam logic [1:0] S_DONE   = 2'd2; // response cycle

   localparam logic [1:0] SZ_BYTE = 2'd0;
   localparam logic [1:0] SZ_HALF = 2'd1;
   localparam logic [1:0] SZ_WORD = 2'd2;

   logic [1:0]            state_q;
   lsu_pkg::lsu_cmd_t     cmd_q;       // latched at acceptance
   logic [`LSU_WIDTH-1:0] result_q;
   logic                  align_q;
   logic                  bus_err_q;

   logic                  accept;
   logic [1:0]            in_size;     // size of incoming command
   logic                  in_align_err;
   logic [1:0]            cur_size;    // size of latched command
   logic                  cur_store;
   logic [3:0]            bsel;
   logic [`LSU_WIDTH-1:0] store_dat;
   logic [`LSU_WIDTH-1:0] load_shifted;
   logic [`LSU_WIDTH-1:0] load_ext;
   logic                  ext_sign;

   // access size from the opcode, anything unknown is a word
   function automatic logic [1:0] lsu_size(input logic [5:0] op);
      case (op)
         `LSU_OP_LBZ, `LSU_OP_LBS, `LSU_OP_SB: lsu_size = SZ_BYTE;
         `LSU_OP_LHZ, `LSU_OP_LHS, `LSU_OP_SH: lsu_size = SZ_HALF;
         default:                             lsu_size = SZ_WORD;
      endcase
   endfunction

   assign cmd_ready_o = (state_q == S_IDLE);
   assign accept      = cmd_valid_i & cmd_ready_o;

   // alignment judged on the raw command so the error answers next cycle
   assign in_size      = lsu_size(cmd_i.opcode);
   assign in_align_err = ((in_size == SZ_WORD) & (|cmd_i.addr[1:0])) |
                         ((in_size == SZ_HALF) & cmd_i.addr[0]);

   assign cur_size  = lsu_size(cmd_q.opcode);
   assign cur_store = (cmd_q.opcode[5:4] == 2'b11);

   // big endian lanes, offset 0 lives in bits 31:24
   always_comb
   begin
      case (cur_size)
         SZ_BYTE: bsel = 4'b1000 >> cmd_q.addr[1:0];
         SZ_HALF: bsel = cmd_q.addr[1] ? 4'b0011 : 4'b1100;
         default: bsel = 4'b1111;
      endcase
   end

   // replicate so every lane carries the operand
   always_comb
   begin
      case (cur_size)
         SZ_BYTE: store_dat = {4{cmd_q.wdata[7:0]}};
         SZ_HALF: store_dat = {2{cmd_q.wdata[15:0]}};
         default: store_dat = cmd_q.wdata;
      endcase
   end

   // move addressed lane to the top, then extend downward
   assign load_shifted = dbus_rsp_i.dat << {cmd_q.addr[1:0], 3'b000};
   assign ext_sign     = ~cmd_q.opcode[0] & load_shifted[`LSU_WIDTH-1]; // bit 0 set = zext

   always_comb
   begin
      case (cur_size)
         SZ_BYTE: load_ext = {{(`LSU_WIDTH-8){ext_sign}}, load_shifted[`LSU_WIDTH-1 -: 8]};
         SZ_HALF: load_ext = {{(`LSU_WIDTH-16){ext_sign}}, load_shifted[`LSU_WIDTH-1 -: 16]};
         default: load_ext = load_shifted;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q   <= S_IDLE;
         align_q   <= 1'b0;
         bus_err_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            S_IDLE:
            begin
               if (accept)
               begin
                  align_q   <= in_align_err;
                  bus_err_q <= 1'b0;
                  state_q   <= in_align_err ? S_DONE : S_ACCESS; // misaligned skips bus
               end
            end
            S_ACCESS:
            begin
               if (dbus_rsp_i.ack | dbus_rsp_i.err)
               begin
                  bus_err_q <= dbus_rsp_i.err;
                  state_q   <= S_DONE;
               end
            end
            default:
               state_q <= S_IDLE; // done lasts one cycle
         endcase
      end
   end

   // payload regs
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cmd_q    <= cmd_i;
         result_q <= '0; // stays zero for stores and faults
      end
      else if ((state_q == S_ACCESS) & dbus_rsp_i.ack & ~cur_store)
         result_q <= load_ext;
   end

   always_comb
   begin
      dbus_req_o.req  = (state_q == S_ACCESS);
      dbus_req_o.we   = cur_store;
      dbus_req_o.adr  = cmd_q.addr;
      dbus_req_o.dat  = store_dat;
      dbus_req_o.bsel = bsel;
   end

   always_comb
   begin
      rsp_o.valid        = (state_q == S_DONE);
      rsp_o.result       = result_q;
      rsp_o.except_align = align_q;
      rsp_o.except_bus   = bus_err_q;
   end

   // request held until the bridge answers
   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      dbus_req_o.req && !dbus_rsp_i.ack && !dbus_rsp_i.err |=> $stable(dbus_req_o));

   a_one_flag: assert property (@(posedge clk) disable iff (rst)
      rsp_o.valid |-> !(rsp_o.except_align && rsp_o.except_bus));

endmodule

`default_nettype wire

// File: design/dbus_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module dbus_axil_bridge
(
   input  wire                 clk,
   input  wire                 rst,
   input  lsu_pkg::dbus_req_t  dbus_req_i,
   output lsu_pkg::dbus_rsp_t  dbus_rsp_o,
   output lsu_pkg::axil_req_t  axil_req_o,
   input  lsu_pkg::axil_rsp_t  axil_rsp_i
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_WR   = 2'd1; // aw/w out, waiting for b
   localparam logic [1:0] S_RD   = 2'd2; // ar out, waiting for r
   localparam logic [1:0] S_RESP = 2'd3; // ack/err pulse

   logic [1:0]            state_q;
   logic                  awvalid_q;
   logic                  wvalid_q;
   logic                  arvalid_q;
   logic [1:0]            resp_q;  // latched bresp/rresp
   logic [`LSU_WIDTH-1:0] rdata_q;

   logic aw_hs;
   logic w_hs;
   logic ar_hs;
   logic b_hs;
   logic r_hs;

   assign aw_hs = awvalid_q & axil_rsp_i.awready;
   assign w_hs  = wvalid_q & axil_rsp_i.wready;
   assign ar_hs = arvalid_q & axil_rsp_i.arready;
   assign b_hs  = axil_rsp_i.bvalid & axil_req_o.bready;
   assign r_hs  = axil_rsp_i.rvalid & axil_req_o.rready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q   <= S_IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            S_IDLE:
            begin
               if (dbus_req_i.req)
               begin
                  awvalid_q <= dbus_req_i.we;  // aw and w raised together
                  wvalid_q  <= dbus_req_i.we;
                  arvalid_q <= ~dbus_req_i.we;
                  state_q   <= dbus_req_i.we ? S_WR : S_RD;
               end
            end
            S_WR:
            begin
               if (aw_hs)
                  awvalid_q <= 1'b0;
               if (w_hs)
                  wvalid_q <= 1'b0;
               if (b_hs)
                  state_q <= S_RESP;
            end
            S_RD:
            begin
               if (ar_hs)
                  arvalid_q <= 1'b0;
               if (r_hs)
                  state_q <= S_RESP;
            end
            default:
               // req is still up during the pulse, going back to idle
               // only afterwards keeps it from restarting
               state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (b_hs)
         resp_q <= axil_rsp_i.bresp;
      else if (r_hs)
      begin
         resp_q  <= axil_rsp_i.rresp;
         rdata_q <= axil_rsp_i.rdata;
      end
   end

   // addresses and data come straight from the held request
   always_comb
   begin
      axil_req_o.awvalid = awvalid_q;
      axil_req_o.awaddr  = dbus_req_i.adr;
      axil_req_o.wvalid  = wvalid_q;
      axil_req_o.wdata   = dbus_req_i.dat;
      axil_req_o.wstrb   = dbus_req_i.bsel; // same lane order both sides
      axil_req_o.bready  = (state_q == S_WR);
      axil_req_o.arvalid = arvalid_q;
      axil_req_o.araddr  = dbus_req_i.adr;
      axil_req_o.rready  = (state_q == S_RD);
   end

   always_comb
   begin
      dbus_rsp_o.ack = (state_q == S_RESP) & (resp_q == `AXI_RESP_OKAY);
      dbus_rsp_o.err = (state_q == S_RESP) & (resp_q != `AXI_RESP_OKAY);
      dbus_rsp_o.dat = rdata_q;
   end

   a_valid_hold: assert property (@(posedge clk) disable iff (rst)
      (awvalid_q && !axil_rsp_i.awready |=> awvalid_q) and
      (wvalid_q && !axil_rsp_i.wready |=> wvalid_q) and
      (arvalid_q && !axil_rsp_i.arready |=> arvalid_q));

endmodule

`default_nettype wire

// File: design/axil_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module axil_data_ram
(
   input  wire                 clk,
   input  wire                 rst,
   input  lsu_pkg::axil_req_t  axil_req_i,
   output lsu_pkg::axil_rsp_t  axil_rsp_o
);

   localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

   logic [`LSU_WIDTH-1:0] mem [0:`LSU_RAM_WORDS-1];

   logic                  bvalid_q;
   logic                  rvalid_q;
   logic [1:0]            bresp_q;
   logic [1:0]            rresp_q;
   logic [`LSU_WIDTH-1:0] rdata_q;

   logic             wr_hs;  // aw and w accepted in one cycle
   logic             ar_hs;
   logic             aw_hit;
   logic             ar_hit;
   logic [IDX_W-1:0] aw_idx;
   logic [IDX_W-1:0] ar_idx;

   // only take aw+w together and only with b drained
   assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
   assign ar_hs = axil_req_i.arvalid & ~rvalid_q;

   assign aw_idx = axil_req_i.awaddr[IDX_W+1:2];
   assign ar_idx = axil_req_i.araddr[IDX_W+1:2];
   assign aw_hit = (axil_req_i.awaddr[`LSU_WIDTH-1:IDX_W+2] == '0); // above end = decerr
   assign ar_hit = (axil_req_i.araddr[`LSU_WIDTH-1:IDX_W+2] == '0);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end
      else
      begin
         if (wr_hs)
            bvalid_q <= 1'b1;
         else if (axil_req_i.bready)
            bvalid_q <= 1'b0;
         if (ar_hs)
            rvalid_q <= 1'b1;
         else if (axil_req_i.rready)
            rvalid_q <= 1'b0;
      end
   end

   // byte strobe write, misses are dropped
   always_ff @(posedge clk)
   begin
      if (wr_hs)
      begin
         bresp_q <= aw_hit ? `AXI_RESP_OKAY : `AXI_RESP_DECERR;
         for (int i = 0; i < 4; i++)
         begin
            if (aw_hit && axil_req_i.wstrb[i])
               mem[aw_idx][8*i +: 8] <= axil_req_i.wdata[8*i +: 8];
         end
      end
      if (ar_hs)
      begin
         rresp_q <= ar_hit ? `AXI_RESP_OKAY : `AXI_RESP_DECERR;
         rdata_q <= ar_hit ? mem[ar_idx] : '0; // miss reads zero
      end
   end

   always_comb
   begin
      axil_rsp_o.awready = wr_hs;
      axil_rsp_o.wready  = wr_hs;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.arready = ~rvalid_q;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
   end

   a_r_after_ar: assert property (@(posedge clk) disable iff (rst)
      $rose(rvalid_q) |-> $past(ar_hs));

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
   input  wire                clk,
   input  wire                rst,
   input  wire                cmd_valid_i,
   input  lsu_pkg::lsu_cmd_t  cmd_i,
   output logic               cmd_ready_o,
   output lsu_pkg::lsu_rsp_t  rsp_o
);

   lsu_pkg::dbus_req_t dbus_req; // unit to bridge
   lsu_pkg::dbus_rsp_t dbus_rsp;
   lsu_pkg::axil_req_t axil_req; // bridge to ram
   lsu_pkg::axil_rsp_t axil_rsp;

   lsu_unit i_lsu_unit
   (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .cmd_ready_o (cmd_ready_o),
      .rsp_o       (rsp_o),
      .dbus_req_o  (dbus_req),
      .dbus_rsp_i  (dbus_rsp)
   );

   dbus_axil_bridge i_bridge
   (
      .clk        (clk),
      .rst        (rst),
      .dbus_req_i (dbus_req),
      .dbus_rsp_o (dbus_rsp),
      .axil_req_o (axil_req),
      .axil_rsp_i (axil_rsp)
   );

   axil_data_ram i_ram
   (
      .clk        (clk),
      .rst        (rst),
      .axil_req_i (axil_req),
      .axil_rsp_o (axil_rsp)
   );

endmodule

`default_nettype wire

// File: sim/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module tb_lsu_top;

   localparam int         TIMEOUT = 64;     // cycles allowed per wait loop
   localparam logic [1:0] F_NONE  = 2'b00;  // {except_align, except_bus}
   localparam logic [1:0] F_ALIGN = 2'b10;
   localparam logic [1:0] F_BUS   = 2'b01;

   // one table row with the name kept in its own queue
   typedef struct packed {
      logic [5:0]            op;
      logic [`LSU_WIDTH-1:0] addr;
      logic [`LSU_WIDTH-1:0] wdata;
      logic [`LSU_WIDTH-1:0] exp_result;
      logic [1:0]            exp_flags;
   } vec_t;

   logic              clk;
   logic              rst;
   logic              cmd_valid;
   lsu_pkg::lsu_cmd_t cmd;
   logic              cmd_ready;
   lsu_pkg::lsu_rsp_t rsp;

   vec_t                  vec_q [$];
   string                 name_q [$];
   logic [`LSU_WIDTH-1:0] shadow [0:`LSU_RAM_WORDS-1];  // expected ram content
   logic                  written [0:`LSU_RAM_WORDS-1]; // word holds known data
   integer                seed;
   int                    checks;
   int                    mismatches;
   int                    timeouts;

   lsu_top i_dut
   (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid_i (cmd_valid),
      .cmd_i       (cmd),
      .cmd_ready_o (cmd_ready),
      .rsp_o       (rsp)
   );

   always #20 clk = ~clk; // 40 ns period

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
         mismatches++;
      end
   endtask

   // big endian with offset 0 in bits 31:24
   task automatic store_shadow(input logic [5:0] op, input logic [31:0] addr,
                               input logic [31:0] wdata);
      logic [7:0] idx;
      idx = addr[9:2];
      if (op == `LSU_OP_SW)
         shadow[idx] = wdata;
      else if (op == `LSU_OP_SH)
      begin
         if (addr[1])
            shadow[idx][15:0] = wdata[15:0];
         else
            shadow[idx][31:16] = wdata[15:0];
      end
      else
      begin
         case (addr[1:0])
            2'd0:    shadow[idx][31:24] = wdata[7:0];
            2'd1:    shadow[idx][23:16] = wdata[7:0];
            2'd2:    shadow[idx][15:8]  = wdata[7:0];
            default: shadow[idx][7:0]   = wdata[7:0];
         endcase
      end
      written[idx] = 1'b1;
   endtask

   // starts on a falling edge and ends one cycle after the response
   task automatic run_cmd(input string name, input logic [5:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, output lsu_pkg::lsu_rsp_t got,
                          output logic done);
      int cycles;
      cycles = 0;
      done   = 1'b0;
      got    = '0;
      while (!cmd_ready && cycles < TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!cmd_ready)
      begin
         $display("%s: command port never became ready", name);
         timeouts++;
         return;
      end
      cmd_valid    = 1'b1;
      cmd.opcode   = op;
      cmd.addr     = addr;
      cmd.wdata    = wdata;
      @(negedge clk);
      cmd_valid    = 1'b0;
      cmd          = {6'h3f, ~addr, ~wdata}; // junk so the unit must use its own copy
      cycles       = 1;
      while (!rsp.valid && cycles < TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!rsp.valid)
      begin
         $display("%s: no response from the DUT", name);
         timeouts++;
         return;
      end
      got  = rsp;
      done = 1'b1;
      check_val({name, " ready low"}, 32'd0, {31'b0, cmd_ready});
      if (got.except_align)
         check_val({name, " align latency"}, 32'd1, cycles); // bus skipped
      if (op[5:4] == 2'b11 && !got.except_align && !got.except_bus)
         store_shadow(op, addr, wdata);
      @(negedge clk);
      check_val({name, " valid pulse"}, 32'd0, {31'b0, rsp.valid}); // one cycle only
      check_val({name, " ready after"}, 32'd1, {31'b0, cmd_ready});
   endtask

   task automatic add_vec(input string name, input logic [5:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] res,
                          input logic [1:0] flags);
      vec_t v;
      v.op         = op;
      v.addr       = addr;
      v.wdata      = wdata;
      v.exp_result = res;
      v.exp_flags  = flags;
      vec_q.push_back(v);
      name_q.push_back(name);
   endtask

   task automatic build_table();
      // word round trip
      add_vec("sw word",       `LSU_OP_SW,  32'h010, 32'h89ab_cdef, 32'h0000_0000, F_NONE);
      add_vec("lwz word",      `LSU_OP_LWZ, 32'h010, 32'h0,         32'h89ab_cdef, F_NONE);
      add_vec("lws word",      `LSU_OP_LWS, 32'h010, 32'h0,         32'h89ab_cdef, F_NONE);
      // bytes fill a cleared word from the top lane down
      add_vec("sw clear 020",  `LSU_OP_SW,  32'h020, 32'h0,         32'h0,         F_NONE);
      add_vec("sb off0",       `LSU_OP_SB,  32'h020, 32'hffff_ff11, 32'h0,         F_NONE);
      add_vec("lwz after sb0", `LSU_OP_LWZ, 32'h020, 32'h0,         32'h1100_0000, F_NONE);
      add_vec("sb off1",       `LSU_OP_SB,  32'h021, 32'h0000_0022, 32'h0,         F_NONE);
      add_vec("lwz after sb1", `LSU_OP_LWZ, 32'h020, 32'h0,         32'h1122_0000, F_NONE);
      add_vec("sb off2",       `LSU_OP_SB,  32'h022, 32'h0000_ab33, 32'h0,         F_NONE);
      add_vec("lwz after sb2", `LSU_OP_LWZ, 32'h020, 32'h0,         32'h1122_3300, F_NONE);
      add_vec("sb off3",       `LSU_OP_SB,  32'h023, 32'h0000_0044, 32'h0,         F_NONE);
      add_vec("lwz after sb3", `LSU_OP_LWZ, 32'h020, 32'h0,         32'h1122_3344, F_NONE);
      // halfwords with bit 15 set
      add_vec("sh off0",       `LSU_OP_SH,  32'h030, 32'h1234_8001, 32'h0,         F_NONE);
      add_vec("sh off2",       `LSU_OP_SH,  32'h032, 32'h0000_f00d, 32'h0,         F_NONE);
      add_vec("lhz off0",      `LSU_OP_LHZ, 32'h030, 32'h0,         32'h0000_8001, F_NONE);
      add_vec("lhs off0",      `LSU_OP_LHS, 32'h030, 32'h0,         32'hffff_8001, F_NONE);
      add_vec("lhz off2",      `LSU_OP_LHZ, 32'h032, 32'h0,         32'h0000_f00d, F_NONE);
      add_vec("lhs off2",      `LSU_OP_LHS, 32'h032, 32'h0,         32'hffff_f00d, F_NONE);
      add_vec("lwz halves",    `LSU_OP_LWZ, 32'h030, 32'h0,         32'h8001_f00d, F_NONE);
      // byte extension
      add_vec("sw clear 040",  `LSU_OP_SW,  32'h040, 32'h0,         32'h0,         F_NONE);
      add_vec("sb neg",        `LSU_OP_SB,  32'h041, 32'h0000_009c, 32'h0,         F_NONE);
      add_vec("lbz neg",       `LSU_OP_LBZ, 32'h041, 32'h0,         32'h0000_009c, F_NONE);
      add_vec("lbs neg",       `LSU_OP_LBS, 32'h041, 32'h0,         32'hffff_ff9c, F_NONE);
      add_vec("sb pos",        `LSU_OP_SB,  32'h043, 32'h0000_007f, 32'h0,         F_NONE);
      add_vec("lbs pos",       `LSU_OP_LBS, 32'h043, 32'h0,         32'h0000_007f, F_NONE);
      // misaligned accesses leave memory untouched
      add_vec("sw off1",       `LSU_OP_SW,  32'h011, 32'hdead_beef, 32'h0,         F_ALIGN);
      add_vec("sw off2",       `LSU_OP_SW,  32'h012, 32'hdead_beef, 32'h0,         F_ALIGN);
      add_vec("sw off3",       `LSU_OP_SW,  32'h013, 32'hdead_beef, 32'h0,         F_ALIGN);
      add_vec("lwz off2",      `LSU_OP_LWZ, 32'h012, 32'h0,         32'h0,         F_ALIGN);
      add_vec("lws off1",      `LSU_OP_LWS, 32'h011, 32'h0,         32'h0,         F_ALIGN);
      add_vec("sh odd",        `LSU_OP_SH,  32'h031, 32'h0000_5555, 32'h0,         F_ALIGN);
      add_vec("lhs odd",       `LSU_OP_LHS, 32'h033, 32'h0,         32'h0,         F_ALIGN);
      add_vec("lwz kept 010",  `LSU_OP_LWZ, 32'h010, 32'h0,         32'h89ab_cdef, F_NONE);
      add_vec("lwz kept 030",  `LSU_OP_LWZ, 32'h030, 32'h0,         32'h8001_f00d, F_NONE);
      // past the ram end where 0x410 and 0x8000_0020 alias 0x010 and 0x020
      add_vec("sw past end",   `LSU_OP_SW,  32'h410, 32'h55aa_55aa, 32'h0,         F_BUS);
      add_vec("lwz past end",  `LSU_OP_LWZ, 32'h400, 32'h0,         32'h0,         F_BUS);
      add_vec("sb far",        `LSU_OP_SB,  32'h8000_0020, 32'h77, 32'h0,         F_BUS);
      add_vec("lwz wrap 010",  `LSU_OP_LWZ, 32'h010, 32'h0,         32'h89ab_cdef, F_NONE);
      add_vec("lwz wrap 020",  `LSU_OP_LWZ, 32'h020, 32'h0,         32'h1122_3344, F_NONE);
   endtask

   task automatic run_table();
      lsu_pkg::lsu_rsp_t got;
      logic              done;
      foreach (vec_q[i])
      begin
         run_cmd(name_q[i], vec_q[i].op, vec_q[i].addr, vec_q[i].wdata, got, done);
         if (done)
         begin
            check_val({name_q[i], " result"}, vec_q[i].exp_result, got.result);
            check_val({name_q[i], " flags"}, {30'b0, vec_q[i].exp_flags},
                      {30'b0, got.except_align, got.except_bus});
         end
      end
   endtask

   // word traffic in 0x100..0x13c with loads only on known words
   task automatic run_random();
      lsu_pkg::lsu_rsp_t got;
      logic              done;
      logic [31:0]       r;
      logic [31:0]       addr;
      logic [31:0]       data;
      logic [31:0]       exp;
      logic [5:0]        op;
      string             name;
      for (int n = 0; n < 40; n++)
      begin
         r    = $random(seed);
         data = $random(seed);
         addr = 32'h100 | (r & 32'h3c);
         if (r[8] || !written[addr[9:2]]) // op bits kept apart from address bits
            op = `LSU_OP_SW;
         else if (r[9])
            op = `LSU_OP_LWS;
         else
            op = `LSU_OP_LWZ;
         exp  = (op == `LSU_OP_SW) ? 32'h0 : shadow[addr[9:2]]; // stores return zero
         name = $sformatf("random %0d", n);
         run_cmd(name, op, addr, data, got, done);
         if (done)
         begin
            check_val({name, " result"}, exp, got.result);
            check_val({name, " flags"}, 32'd0, {30'b0, got.except_align, got.except_bus});
         end
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      cmd_valid  = 1'b0;
      cmd        = '0;
      seed       = 32'hcffa_674b;
      checks     = 0;
      mismatches = 0;
      timeouts   = 0;
      foreach (written[i])
         written[i] = 1'b0;
      build_table();
      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_val("reset ready", 32'd1, {31'b0, cmd_ready});
      check_val("reset rsp valid", 32'd0, {31'b0, rsp.valid});
      run_table();
      run_random();
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0 && checks > 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: lsu_sub.f
+incdir+design
design/lsu_pkg.sv
design/lsu_unit.sv
design/dbus_axil_bridge.sv
design/axil_data_ram.sv
design/lsu_top.sv
sim/tb_lsu_top.sv

// File: Makefile
# Verilator flow for the load/store subsystem
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= lsu_sub.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TESTS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
